// ==== Makefile ====
TOP = tb_cart_top

sim:
	verilator --binary --timing --timescale 1ns/1ps --top-module $(TOP) -f src.f -o sim_bin
	out=$$(./obj_dir/sim_bin); echo "$$out"; echo "$$out" | grep -q "No errors"

clean:
	rm -rf obj_dir

.PHONY: sim clean

// ==== logic/cart_addr_map.sv ====
`timescale 1ns/1ps
`include "cart_settings.svh"

module cart_addr_map (
  input  logic                  CLK,
  input  logic                  reset,
  input  cart_map_pkg::mapper_t mapper,
  input  logic [7:0]            featurebits,
  input  logic [`SNES_AW-1:0]   rom_mask,
  input  logic [`SNES_AW-1:0]   saveram_mask,
  input  logic [`SNES_AW-1:0]   snes_addr,
  input  logic [7:0]            snes_pa,       // B-bus peripheral address
  output logic [`SNES_AW-1:0]   rom_addr,      // Cartridge SRAM address
  output logic                  rom_hit,
  output logic                  is_rom,
  output logic                  is_saveram,
  output logic                  is_writable,
  output logic                  msu_enable,
  output logic                  srtc_enable,
  output logic                  dspx_enable,
  output logic                  dspx_dp_enable,
  output logic                  dspx_a0,
  output logic                  r213f_enable,
  output logic                  snescmd_enable
);

  import cart_map_pkg::*;

  snes_addr_u          sa;
  logic [`SNES_AW-1:0] w;
  logic [7:0]          bank;
  logic [15:0]         ofs;
  logic                map_ok;
  logic                sram_win;
  logic                sram_d;
  logic                rom_d;
  logic [`SNES_AW-1:0] addr_d;
  logic                dspx_d;
  logic                a0_d;

  assign sa   = snes_addr;
  assign w    = sa.word;
  assign bank = sa.part.bank;
  assign ofs  = sa.part.offset;

  // BSX and the unused codes decode to no hit
  assign map_ok = mapper inside {map_hirom, map_lorom, map_exhirom,
                                 map_interleaved, map_menu};

  ////////////////////////////////////////////////////////////////////////////
  // Area test

  always_comb begin
    if (featurebits[feat_st0010]) begin
      // ST0010 battery RAM at 68-6F:0800-0FFF
      sram_win = (w[22:19] == 4'b1101) && (ofs[15:12] == 4'h0) && ofs[11];
    end else begin
      case (mapper)
        // Interleaved layout shares the HiROM window
        map_hirom, map_exhirom, map_interleaved:
          sram_win = (bank[6:5] == 2'b01) && (ofs[15:13] == 3'b011);
        // 70-7D with the upper half as ROM for images of 32 Mbit and up
        map_lorom:
          sram_win = (bank[6:4] == 3'b111) && (bank[3:0] < 4'hE) &&
                     (!ofs[15] || !rom_mask[21]);
        map_menu: sram_win = (bank == 8'hFF);
        default:  sram_win = 1'b0;
      endcase
    end
  end

  assign sram_d = map_ok & saveram_mask[0] & sram_win; // No save-RAM with empty mask
  assign rom_d  = map_ok & (w[22] | ofs[15]);

  ////////////////////////////////////////////////////////////////////////////
  // Address arithmetic

  always_comb begin
    case (mapper)
      map_hirom, map_exhirom: begin
        if (sram_d) begin
          addr_d = 24'hE00000 + ({6'b0, w[20:16], w[12:0]} & saveram_mask);
        end else if (mapper == map_hirom) begin
          addr_d = {1'b0, w[22:0]} & rom_mask;
        end else begin
          addr_d = {1'b0, !w[23], w[21:0]} & rom_mask; // Low banks go high
        end
      end
      map_lorom: begin
        if (sram_d) begin
          addr_d = 24'hE00000 + ({4'b0, w[20:16], ofs[14:0]} & saveram_mask);
        end else begin
          addr_d = {2'b00, w[22:16], ofs[14:0]} & rom_mask;
        end
      end
      map_interleaved: begin
        if (sram_d) begin
          addr_d = 24'hE00000 + ({9'b0, ofs[14:0] - 15'h6000} & saveram_mask);
        end else if (ofs[15]) begin
          addr_d = {1'b0, bank, ofs[14:0]} & rom_mask;
        end else begin
          // Lower half of each bank lives above 8 MB
          addr_d = {2'b10, w[23], w[21:16], ofs[14:0]} & rom_mask;
        end
      end
      map_menu: begin
        if (sram_d) begin
          addr_d = w;
        end else begin
          addr_d = ({1'b0, w[22:0]} & rom_mask) + 24'hC00000;
        end
      end
      default: addr_d = '0;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Coprocessor windows

  always_comb begin
    dspx_d = 1'b0;
    a0_d   = 1'b1;
    if (featurebits[feat_dspx]) begin
      if (mapper == map_lorom) begin
        // DR/SR at 30-3F:8000-FFFF or 60-6F:0000-7FFF for big ROMs
        dspx_d = rom_mask[20] ? (w[22] & w[21] & !w[20] & !ofs[15])
                              : (!w[22] & w[21] & w[20] & ofs[15]);
        a0_d   = ofs[14];
      end else if (mapper == map_hirom) begin
        dspx_d = !w[22] & !w[21] & !w[20] & (ofs[15:13] == 3'b011); // 00-0F:6000
        a0_d   = ofs[12];
      end
    end else if (featurebits[feat_st0010]) begin
      dspx_d = w[22] & w[21] & !w[20] & (w[19:16] == 4'h0) & !ofs[15];
      a0_d   = ofs[0];
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Output registers

  always_ff @(posedge CLK) begin
    if (reset) begin
      is_rom         <= 1'b0;
      is_saveram     <= 1'b0;
      is_writable    <= 1'b0;
      rom_hit        <= 1'b0;
      msu_enable     <= 1'b0;
      srtc_enable    <= 1'b0;
      dspx_enable    <= 1'b0;
      dspx_dp_enable <= 1'b0;
      dspx_a0        <= 1'b0;
      r213f_enable   <= 1'b0;
      snescmd_enable <= 1'b0;
    end else begin
      is_rom         <= rom_d;
      is_saveram     <= sram_d;
      is_writable    <= sram_d;
      rom_hit        <= rom_d | sram_d;
      msu_enable     <= featurebits[feat_msu1] & !w[22] &
                        ((ofs & 16'hFFF8) == 16'h2000);
      srtc_enable    <= featurebits[feat_srtc] & !w[22] &
                        ((ofs & 16'hFFFE) == 16'h2800);
      dspx_enable    <= dspx_d;
      dspx_dp_enable <= featurebits[feat_st0010] & (w[22:19] == 4'b1101) &
                        (ofs[15:11] == 5'b00000);
      dspx_a0        <= a0_d;
      r213f_enable   <= featurebits[feat_213f] & (snes_pa == 8'h3F);
      snescmd_enable <= !w[22] & (ofs[15:8] == 8'h2A); // Page 2A of the low banks
    end
  end

  always_ff @(posedge CLK) begin
    rom_addr <= addr_d;
  end

endmodule

// ==== logic/cart_config_regs.sv ====
`timescale 1ns/1ps
`include "cart_settings.svh"

module cart_config_regs (
  input  logic                    CLK,
  input  logic                    reset,
  // Write address and data
  input  logic [`AXI_AW-1:0]      s_awaddr,
  input  logic                    s_awvalid,
  output logic                    s_awready,
  input  logic [`AXI_DW-1:0]      s_wdata,
  input  logic                    s_wvalid,
  output logic                    s_wready,
  // Write response
  output cfg_bus_pkg::resp_t      s_bresp,
  output logic                    s_bvalid,
  input  logic                    s_bready,
  // Read address and data
  input  logic [`AXI_AW-1:0]      s_araddr,
  input  logic                    s_arvalid,
  output logic                    s_arready,
  output logic [`AXI_DW-1:0]      s_rdata,
  output cfg_bus_pkg::resp_t      s_rresp,
  output logic                    s_rvalid,
  input  logic                    s_rready,
  // Map configuration
  output cart_map_pkg::mapper_t   mapper,
  output logic [7:0]              featurebits,
  output logic [`SNES_AW-1:0]     rom_mask,
  output logic [`SNES_AW-1:0]     saveram_mask
);

  import cart_map_pkg::*;
  import cfg_bus_pkg::*;

  logic               wr_fire;
  logic               rd_fire;
  logic [`AXI_DW-1:0] rd_word;

  // True for the four register offsets only
  function automatic logic addr_known(input logic [`AXI_AW-1:0] addr);
    return (addr == reg_mapper) || (addr == reg_features) ||
           (addr == reg_rom_mask) || (addr == reg_sram_mask);
  endfunction

  assign wr_fire = s_awready & s_awvalid & s_wready & s_wvalid;
  assign rd_fire = s_arready & s_arvalid;

  ////////////////////////////////////////////////////////////////////////////
  // Write channel and register file

  always_ff @(posedge CLK) begin
    if (reset) begin
      s_awready    <= 1'b0;
      s_wready     <= 1'b0;
      s_bvalid     <= 1'b0;
      mapper       <= map_hirom;
      featurebits  <= 8'h00;
      rom_mask     <= `ROM_MASK_RST;
      saveram_mask <= `SRAM_MASK_RST;
    end else begin
      s_awready <= 1'b0; // One cycle pulse
      s_wready  <= 1'b0;
      if (wr_fire) begin
        s_bvalid <= 1'b1;
        case (s_awaddr)
          reg_mapper:    mapper       <= mapper_t'(s_wdata[2:0]);
          reg_features:  featurebits  <= s_wdata[7:0];
          reg_rom_mask:  rom_mask     <= s_wdata[`SNES_AW-1:0];
          reg_sram_mask: saveram_mask <= s_wdata[`SNES_AW-1:0];
          default: ;                     // Unmapped, nothing changes
        endcase
      end else if (s_bvalid && s_bready) begin
        s_bvalid <= 1'b0;
      end
      // Accept the next write only with no response pending
      if (s_awvalid && s_wvalid && !s_awready && !s_bvalid) begin
        s_awready <= 1'b1;
        s_wready  <= 1'b1;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (wr_fire) begin
      s_bresp <= addr_known(s_awaddr) ? resp_okay : resp_slverr;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Read channel

  // Read-back, upper bits padded with zero
  always_comb begin
    case (s_araddr)
      reg_mapper:    rd_word = {{(`AXI_DW-3){1'b0}}, mapper};
      reg_features:  rd_word = {{(`AXI_DW-8){1'b0}}, featurebits};
      reg_rom_mask:  rd_word = {{(`AXI_DW-`SNES_AW){1'b0}}, rom_mask};
      reg_sram_mask: rd_word = {{(`AXI_DW-`SNES_AW){1'b0}}, saveram_mask};
      default:       rd_word = '0;
    endcase
  end

  always_ff @(posedge CLK) begin
    if (reset) begin
      s_arready <= 1'b0;
      s_rvalid  <= 1'b0;
    end else begin
      s_arready <= 1'b0;
      if (rd_fire) begin
        s_rvalid <= 1'b1;
      end else if (s_rvalid && s_rready) begin
        s_rvalid <= 1'b0;
      end
      if (s_arvalid && !s_arready && !s_rvalid) begin
        s_arready <= 1'b1;
      end
    end
  end

  // Data and response held with rvalid
  always_ff @(posedge CLK) begin
    if (rd_fire) begin
      s_rdata <= rd_word;
      s_rresp <= addr_known(s_araddr) ? resp_okay : resp_slverr;
    end
  end

endmodule

// ==== logic/cart_map_pkg.sv ====
`include "cart_settings.svh"

package cart_map_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Mapper codes as set by the host

  typedef enum logic [2:0] {
    map_hirom       = 3'b000,
    map_lorom       = 3'b001,
    map_exhirom     = 3'b010, // 48 to 64 Mbit
    map_bsx         = 3'b011, // Not decoded, no hit
    map_interleaved = 3'b110, // 96 Mbit split layout
    map_menu        = 3'b111  // Menu ROM in upper SRAM
  } mapper_t;

  ////////////////////////////////////////////////////////////////////////////
  // Bit positions in the feature word

  localparam int feat_dspx   = 0;
  localparam int feat_st0010 = 1;
  localparam int feat_srtc   = 2;
  localparam int feat_msu1   = 3;
  localparam int feat_213f   = 4;

  ////////////////////////////////////////////////////////////////////////////
  // SNES A-bus address

  typedef struct packed {
    logic [7:0]  bank;
    logic [15:0] offset;
  } snes_addr_part_t;

  // Flat word for single bit tests, bank and offset for window compares
  typedef union packed {
    logic [`SNES_AW-1:0] word;
    snes_addr_part_t     part;
  } snes_addr_u;

endpackage

// ==== logic/cart_mem_request.sv ====
`timescale 1ns/1ps
`include "cart_settings.svh"

module cart_mem_request (
  input  logic                CLK,
  input  logic                reset,
  input  logic                snes_rd_n,   // Asynchronous strobes
  input  logic                snes_wr_n,
  input  logic                rom_hit,
  input  logic                is_writable,
  input  logic [`SNES_AW-1:0] rom_addr,
  output logic                mem_rd,
  output logic                mem_wr,
  output logic [`SNES_AW-1:0] mem_addr
);

  // [0] and [1] synchronize, [2] holds the previous synced level
  logic [2:0] rd_pipe;
  logic [2:0] wr_pipe;
  logic       rd_fall;
  logic       wr_fall;
  logic       rd_go;
  logic       wr_go;

  ////////////////////////////////////////////////////////////////////////////
  // Strobe synchronizer and edge detect

  always_ff @(posedge CLK) begin
    if (reset) begin
      rd_pipe <= 3'b111; // Idle high
      wr_pipe <= 3'b111;
    end else begin
      rd_pipe <= {rd_pipe[1:0], snes_rd_n};
      wr_pipe <= {wr_pipe[1:0], snes_wr_n};
    end
  end

  assign rd_fall = rd_pipe[2] & !rd_pipe[1];
  assign wr_fall = wr_pipe[2] & !wr_pipe[1];

  // Writes to ROM are dropped here
  assign rd_go = rd_fall & rom_hit;
  assign wr_go = wr_fall & rom_hit & is_writable;

  ////////////////////////////////////////////////////////////////////////////
  // Request pulses

  always_ff @(posedge CLK) begin
    if (reset) begin
      mem_rd <= 1'b0;
      mem_wr <= 1'b0;
    end else begin
      mem_rd <= rd_go; // Single cycle per access
      mem_wr <= wr_go;
    end
  end

  // Address travels with the pulse
  always_ff @(posedge CLK) begin
    if (rd_go || wr_go) begin
      mem_addr <= rom_addr;
    end
  end

endmodule

// ==== logic/cart_settings.svh ====
`ifndef CART_SETTINGS_SVH
`define CART_SETTINGS_SVH

// SNES side
`define SNES_AW 24              // Bank plus offset

// Host configuration bus
`define AXI_AW 4                // Four 32-bit registers
`define AXI_DW 32

// Mask defaults out of reset
`define ROM_MASK_RST 24'hFFFFFF  // Full 128 Mbit window
`define SRAM_MASK_RST 24'h001FFF // 8 KB save-RAM

`endif

// ==== logic/cart_top.sv ====
`timescale 1ns/1ps
`include "cart_settings.svh"

module cart_top (
  input  logic                CLK,
  input  logic                reset,
  // Host configuration bus
  input  logic [`AXI_AW-1:0]  s_awaddr,
  input  logic                s_awvalid,
  output logic                s_awready,
  input  logic [`AXI_DW-1:0]  s_wdata,
  input  logic                s_wvalid,
  output logic                s_wready,
  output cfg_bus_pkg::resp_t  s_bresp,
  output logic                s_bvalid,
  input  logic                s_bready,
  input  logic [`AXI_AW-1:0]  s_araddr,
  input  logic                s_arvalid,
  output logic                s_arready,
  output logic [`AXI_DW-1:0]  s_rdata,
  output cfg_bus_pkg::resp_t  s_rresp,
  output logic                s_rvalid,
  input  logic                s_rready,
  // SNES bus
  input  logic [`SNES_AW-1:0] snes_addr,
  input  logic [7:0]          snes_pa,
  input  logic                snes_rd_n,
  input  logic                snes_wr_n,
  // Decode results
  output logic                rom_hit,
  output logic                is_rom,
  output logic                is_saveram,
  output logic                is_writable,
  output logic                msu_enable,
  output logic                srtc_enable,
  output logic                dspx_enable,
  output logic                dspx_dp_enable,
  output logic                dspx_a0,
  output logic                r213f_enable,
  output logic                snescmd_enable,
  // Memory request
  output logic                mem_rd,
  output logic                mem_wr,
  output logic [`SNES_AW-1:0] mem_addr
);

  import cart_map_pkg::*;

  mapper_t             mapper;
  logic [7:0]          featurebits;
  logic [`SNES_AW-1:0] rom_mask;
  logic [`SNES_AW-1:0] saveram_mask;
  logic [`SNES_AW-1:0] rom_addr;

  cart_config_regs u_regs (
    .CLK          (CLK),
    .reset        (reset),
    .s_awaddr     (s_awaddr),
    .s_awvalid    (s_awvalid),
    .s_awready    (s_awready),
    .s_wdata      (s_wdata),
    .s_wvalid     (s_wvalid),
    .s_wready     (s_wready),
    .s_bresp      (s_bresp),
    .s_bvalid     (s_bvalid),
    .s_bready     (s_bready),
    .s_araddr     (s_araddr),
    .s_arvalid    (s_arvalid),
    .s_arready    (s_arready),
    .s_rdata      (s_rdata),
    .s_rresp      (s_rresp),
    .s_rvalid     (s_rvalid),
    .s_rready     (s_rready),
    .mapper       (mapper),
    .featurebits  (featurebits),
    .rom_mask     (rom_mask),
    .saveram_mask (saveram_mask)
  );

  cart_addr_map u_map (
    .CLK            (CLK),
    .reset          (reset),
    .mapper         (mapper),
    .featurebits    (featurebits),
    .rom_mask       (rom_mask),
    .saveram_mask   (saveram_mask),
    .snes_addr      (snes_addr),
    .snes_pa        (snes_pa),
    .rom_addr       (rom_addr),
    .rom_hit        (rom_hit),
    .is_rom         (is_rom),
    .is_saveram     (is_saveram),
    .is_writable    (is_writable),
    .msu_enable     (msu_enable),
    .srtc_enable    (srtc_enable),
    .dspx_enable    (dspx_enable),
    .dspx_dp_enable (dspx_dp_enable),
    .dspx_a0        (dspx_a0),
    .r213f_enable   (r213f_enable),
    .snescmd_enable (snescmd_enable)
  );

  cart_mem_request u_req (
    .CLK         (CLK),
    .reset       (reset),
    .snes_rd_n   (snes_rd_n),
    .snes_wr_n   (snes_wr_n),
    .rom_hit     (rom_hit),
    .is_writable (is_writable),
    .rom_addr    (rom_addr),
    .mem_rd      (mem_rd),
    .mem_wr      (mem_wr),
    .mem_addr    (mem_addr)
  );

endmodule

// ==== logic/cfg_bus_pkg.sv ====
`include "cart_settings.svh"

package cfg_bus_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Register map, byte offsets

  localparam logic [`AXI_AW-1:0] reg_mapper    = 'h0; // Mapper code
  localparam logic [`AXI_AW-1:0] reg_features  = 'h4; // Feature enables
  localparam logic [`AXI_AW-1:0] reg_rom_mask  = 'h8;
  localparam logic [`AXI_AW-1:0] reg_sram_mask = 'hC;

  ////////////////////////////////////////////////////////////////////////////
  // AXI response codes

  typedef logic [1:0] resp_t;

  localparam resp_t resp_okay   = 2'b00;
  localparam resp_t resp_slverr = 2'b10; // Unmapped offset

endpackage

// ==== sim/tb_cart_model.svh ====
`ifndef TB_CART_MODEL_SVH
`define TB_CART_MODEL_SVH

////////////////////////////////////////////////////////////////////////////
// Shadow register file and random source

logic [2:0]  sh_mapper;
logic [7:0]  sh_feat;
logic [23:0] sh_rom_mask;
logic [23:0] sh_sram_mask;
logic [15:0] lfsr_state;

// Galois LFSR on x^16 + x^14 + x^13 + x^11 + 1 stepped once per bit
function automatic logic [31:0] rand_bits(input int n);
  logic [31:0] r;
  int          i;
  r = '0;
  for (i = 0; i < n; i++) begin
    r = {r[30:0], lfsr_state[0]};
    lfsr_state = {1'b0, lfsr_state[15:1]} ^ (lfsr_state[0] ? 16'hB400 : 16'h0000);
  end
  return r;
endfunction

task automatic store_shadow(input logic [3:0] addr, input logic [31:0] data);
  case (addr)
    reg_mapper:    sh_mapper = data[2:0];
    reg_features:  sh_feat = data[7:0];
    reg_rom_mask:  sh_rom_mask = data[23:0];
    reg_sram_mask: sh_sram_mask = data[23:0];
    default: ;  // Unmapped offset
  endcase
endtask

function automatic logic [31:0] expected_rdata(input logic [3:0] addr);
  case (addr)
    reg_mapper:    return {29'd0, sh_mapper};
    reg_features:  return {24'd0, sh_feat};
    reg_rom_mask:  return {8'd0, sh_rom_mask};
    reg_sram_mask: return {8'd0, sh_sram_mask};
    default:       return 32'd0;
  endcase
endfunction

////////////////////////////////////////////////////////////////////////////
// Decode model

function automatic logic saveram_hit(input logic [23:0] a);
  logic [7:0]  b;
  logic [15:0] o;
  logic        win;
  logic        ok;
  b = a[23:16] & 8'h7F;  // Upper banks mirror the lower ones
  o = a[15:0];
  // BSX and the unused codes never hit
  ok = sh_mapper inside {map_hirom, map_lorom, map_exhirom, map_interleaved, map_menu};
  if (sh_feat[feat_st0010]) begin
    win = (b >= 8'h68) && (b <= 8'h6F) && (o >= 16'h0800) && (o <= 16'h0FFF);
  end else begin
    case (sh_mapper)
      map_hirom, map_exhirom, map_interleaved:
        win = (b >= 8'h20) && (b <= 8'h3F) && (o >= 16'h6000) && (o <= 16'h7FFF);
      map_lorom:
        win = (b >= 8'h70) && (b <= 8'h7D) && ((o < 16'h8000) || !sh_rom_mask[21]);
      map_menu: win = (a[23:16] == 8'hFF);
      default:  win = 1'b0;
    endcase
  end
  return win && ok && (sh_sram_mask != 24'd0);
endfunction

function automatic logic rom_area(input logic [23:0] a);
  logic ok;
  ok = sh_mapper inside {map_hirom, map_lorom, map_exhirom, map_interleaved, map_menu};
  return ok && (((a[23:16] & 8'h40) != 8'h00) || (a[15:0] >= 16'h8000));
endfunction

function automatic logic [23:0] mapped_addr(input logic [23:0] a);
  logic [7:0]  b;
  logic [15:0] o;
  logic [15:0] d;
  logic        s;
  b = a[23:16];
  o = a[15:0];
  d = o - 16'h6000;
  s = saveram_hit(a);
  case (sh_mapper)
    map_hirom, map_exhirom: begin
      if (s) begin
        return 24'hE00000 + ((24'(b[4:0]) * 24'h2000 + 24'(o[12:0])) & sh_sram_mask);
      end else if (sh_mapper == map_hirom) begin
        return (a % 24'h800000) & sh_rom_mask;
      end
      return ((b[7] ? 24'h000000 : 24'h400000) + (a % 24'h400000)) & sh_rom_mask;
    end
    map_lorom: begin
      if (s) begin
        return 24'hE00000 + ((24'(b[4:0]) * 24'h8000 + 24'(o[14:0])) & sh_sram_mask);
      end
      return (24'(b[6:0]) * 24'h8000 + 24'(o[14:0])) & sh_rom_mask;
    end
    map_interleaved: begin
      if (s) return 24'hE00000 + (24'(d[14:0]) & sh_sram_mask);
      if (o >= 16'h8000) return (24'(b) * 24'h8000 + 24'(o[14:0])) & sh_rom_mask;
      // Lower halves start at 8 MB
      return (24'h800000 + (b[7] ? 24'h200000 : 24'h000000) +
              24'(b[5:0]) * 24'h8000 + 24'(o[14:0])) & sh_rom_mask;
    end
    map_menu: begin
      if (s) return a;
      return ((a % 24'h800000) & sh_rom_mask) + 24'hC00000;
    end
    default: return 24'd0;
  endcase
endfunction

// {msu, srtc, dspx, dspx_dp, dspx_a0, r213f, snescmd}
function automatic logic [6:0] periph_enables(input logic [23:0] a, input logic [7:0] pa);
  logic [7:0]  b;
  logic [15:0] o;
  logic        low_bank;
  logic        dsp;
  logic        a0;
  b = a[23:16];
  o = a[15:0];
  low_bank = (b & 8'h40) == 8'h00;
  dsp = 1'b0;
  a0 = 1'b1;
  if (sh_feat[feat_dspx]) begin
    if (sh_mapper == map_lorom) begin
      if (sh_rom_mask[20]) dsp = ((b & 8'h70) == 8'h60) && (o < 16'h8000);
      else dsp = ((b & 8'h70) == 8'h30) && (o >= 16'h8000);
      a0 = o[14];
    end else if (sh_mapper == map_hirom) begin
      dsp = ((b & 8'h70) == 8'h00) && (o >= 16'h6000) && (o < 16'h8000);
      a0 = o[12];
    end
  end else if (sh_feat[feat_st0010]) begin
    dsp = ((b & 8'h7F) == 8'h60) && (o < 16'h8000);
    a0 = o[0];
  end
  return {sh_feat[feat_msu1] && low_bank && (o >= 16'h2000) && (o <= 16'h2007),
          sh_feat[feat_srtc] && low_bank && ((o == 16'h2800) || (o == 16'h2801)),
          dsp,
          sh_feat[feat_st0010] && ((b & 8'h78) == 8'h68) && (o < 16'h0800),
          a0,
          sh_feat[feat_213f] && (pa == 8'h3F),
          low_bank && (o[15:8] == 8'h2A)};
endfunction

`endif

// ==== sim/tb_cart_top.sv ====
`timescale 1ns/1ps
`include "cart_settings.svh"

module tb_cart_top;

  import cart_map_pkg::*;
  import cfg_bus_pkg::*;

  // Register phase plus six mappers, six configs of four writes and ten accesses
  localparam int n_trans = 60 + 6 * 6 * (4 + 10);

  logic                CLK = 1'b0;
  logic                reset;
  logic [`AXI_AW-1:0]  s_awaddr;
  logic                s_awvalid, s_awready;
  logic [`AXI_DW-1:0]  s_wdata;
  logic                s_wvalid, s_wready;
  resp_t               s_bresp;
  logic                s_bvalid, s_bready;
  logic [`AXI_AW-1:0]  s_araddr;
  logic                s_arvalid, s_arready;
  logic [`AXI_DW-1:0]  s_rdata;
  resp_t               s_rresp;
  logic                s_rvalid, s_rready;
  logic [`SNES_AW-1:0] snes_addr;
  logic [7:0]          snes_pa;
  logic                snes_rd_n, snes_wr_n;
  logic                rom_hit, is_rom, is_saveram, is_writable;
  logic                msu_enable, srtc_enable, dspx_enable, dspx_dp_enable;
  logic                dspx_a0, r213f_enable, snescmd_enable;
  logic                mem_rd, mem_wr;
  logic [`SNES_AW-1:0] mem_addr;

  `include "tb_cart_model.svh"

  cart_top dut0 (.*);

  always #50 CLK = ~CLK;

  initial begin
    #((n_trans * 20 + 500) * 100);
    $display("Timed out before all transactions completed");
    $display("Errors found");
    $fatal(1, "Watchdog expired");
  end

  ////////////////////////////////////////////////////////////////////////////
  // Helpers

  task automatic next_cycle();
    @(posedge CLK);
    #10;  // Drive and sample away from the edge
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("** Error: %s got %h expected %h", name, got, exp);
      $display("Errors found");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  // Only the four word-aligned offsets are mapped
  function automatic logic [1:0] expected_resp(input logic [3:0] addr);
    return (addr[1:0] == 2'b00) ? resp_okay : resp_slverr;
  endfunction

  task automatic axi_write(input logic [3:0] addr, input logic [31:0] data);
    s_awaddr = addr;
    s_wdata = data;
    s_awvalid = 1'b1;
    s_wvalid = 1'b1;
    do next_cycle(); while (!s_awready);
    check_value("s_wready", 32'(s_wready), 32'd1);
    next_cycle();
    s_awvalid = 1'b0;
    s_wvalid = 1'b0;
    s_bready = 1'b1;
    while (!s_bvalid) next_cycle();
    check_value("s_bresp", 32'(s_bresp), 32'(expected_resp(addr)));
    next_cycle();
    s_bready = 1'b0;
    store_shadow(addr, data);
  endtask

  task automatic axi_read(input logic [3:0] addr);
    s_araddr = addr;
    s_arvalid = 1'b1;
    do next_cycle(); while (!s_arready);
    next_cycle();
    s_arvalid = 1'b0;
    s_rready = 1'b1;
    while (!s_rvalid) next_cycle();
    check_value("s_rresp", 32'(s_rresp), 32'(expected_resp(addr)));
    if (expected_resp(addr) == resp_okay) begin
      check_value("s_rdata", s_rdata, expected_rdata(addr));
    end
    next_cycle();
    s_rready = 1'b0;
  endtask

  task automatic configure_map(input logic [2:0] m, input logic [7:0] f,
                               input logic [23:0] rm, input logic [23:0] sm);
    axi_write(reg_mapper, {29'd0, m});
    axi_write(reg_features, {24'd0, f});
    axi_write(reg_rom_mask, {8'd0, rm});
    axi_write(reg_sram_mask, {8'd0, sm});
  endtask

  // Biased toward the peripheral, DSP and save-RAM windows
  function automatic logic [23:0] random_addr();
    logic [7:0]  b;
    logic [15:0] o;
    b = 8'(rand_bits(8));
    o = 16'(rand_bits(16));
    case (3'(rand_bits(3)))
      3'd0: o = 16'h2000 | 16'(rand_bits(4));
      3'd1: o = 16'h2800 | 16'(rand_bits(2));
      3'd2: o = 16'h2A00 | 16'(rand_bits(8));
      3'd3: b[6:4] = (rand_bits(1) != 0) ? 3'b011 : ((rand_bits(1) != 0) ? 3'b110 : 3'b000);
      3'd4: begin
        b[6:5] = 2'b01;
        o = 16'h6000 | 16'(rand_bits(13));
      end
      3'd5: begin
        b[6:3] = 4'b1101;  // ST0010 area
        o = 16'(rand_bits(12));
      end
      3'd6: b = (rand_bits(1) != 0) ? 8'hFF : {b[7], 3'b111, b[3:0]};
      default: ;
    endcase
    return {b, o};
  endfunction

  task automatic bus_access(input logic [23:0] a, input logic [7:0] pa, input logic is_write);
    logic [6:0]  pe;
    logic        hit;
    logic        wrt;
    logic [23:0] ea;
    int          i;
    snes_addr = a;
    snes_pa = pa;
    pe = periph_enables(a, pa);
    wrt = saveram_hit(a);
    hit = rom_area(a) || wrt;
    ea = mapped_addr(a);
    next_cycle();
    check_value("is_rom", 32'(is_rom), 32'(rom_area(a)));
    check_value("is_saveram", 32'(is_saveram), 32'(wrt));
    check_value("is_writable", 32'(is_writable), 32'(wrt));
    check_value("rom_hit", 32'(rom_hit), 32'(hit));
    check_value("msu_enable", 32'(msu_enable), 32'(pe[6]));
    check_value("srtc_enable", 32'(srtc_enable), 32'(pe[5]));
    check_value("dspx_enable", 32'(dspx_enable), 32'(pe[4]));
    check_value("dspx_dp_enable", 32'(dspx_dp_enable), 32'(pe[3]));
    check_value("dspx_a0", 32'(dspx_a0), 32'(pe[2]));
    check_value("r213f_enable", 32'(r213f_enable), 32'(pe[1]));
    check_value("snescmd_enable", 32'(snescmd_enable), 32'(pe[0]));
    if (is_write) snes_wr_n = 1'b0;
    else snes_rd_n = 1'b0;
    for (i = 1; i <= 5; i++) begin
      next_cycle();
      check_value("mem_rd", 32'(mem_rd), 32'(!is_write && hit && (i == 3)));
      check_value("mem_wr", 32'(mem_wr), 32'(is_write && wrt && (i == 3)));
      if ((i == 3) && (is_write ? wrt : hit)) begin
        check_value("mem_addr", 32'(mem_addr), 32'(ea));
      end
    end
    snes_rd_n = 1'b1;
    snes_wr_n = 1'b1;
    repeat (3) begin  // Rising edge makes no request
      next_cycle();
      check_value("mem_rd", 32'(mem_rd), 32'd0);
      check_value("mem_wr", 32'(mem_wr), 32'd0);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence

  initial begin
    logic [2:0] map_list [6];
    int         m;
    int         c;
    int         n;
    map_list = '{map_hirom, map_lorom, map_exhirom, map_bsx, map_interleaved, map_menu};
    lfsr_state = 16'd5405;
    reset = 1'b1;
    s_awaddr = '0;
    s_awvalid = 1'b0;
    s_wdata = '0;
    s_wvalid = 1'b0;
    s_bready = 1'b0;
    s_araddr = '0;
    s_arvalid = 1'b0;
    s_rready = 1'b0;
    snes_addr = '0;
    snes_pa = '0;
    snes_rd_n = 1'b1;
    snes_wr_n = 1'b1;
    sh_mapper = map_hirom;
    sh_feat = 8'h00;
    sh_rom_mask = `ROM_MASK_RST;
    sh_sram_mask = `SRAM_MASK_RST;
    repeat (3) @(posedge CLK);
    #10;
    reset = 1'b0;

    // Reset state
    check_value("decode flags", 32'({rom_hit, is_rom, is_saveram, is_writable,
                msu_enable, srtc_enable, dspx_enable, dspx_dp_enable, dspx_a0,
                r213f_enable, snescmd_enable}), 32'd0);
    check_value("mem_rd/mem_wr", 32'({mem_rd, mem_wr}), 32'd0);
    for (n = 0; n < 4; n++) axi_read(4'(n * 4));

    // Register access
    repeat (12) begin
      axi_write({2'(rand_bits(2)), 2'b00}, rand_bits(32));
    end
    for (n = 0; n < 4; n++) axi_read(4'(n * 4));
    axi_write(4'h2, rand_bits(32));
    axi_read(4'h2);
    for (n = 0; n < 4; n++) axi_read(4'(n * 4));

    // Decode, peripheral windows and memory requests
    for (m = 0; m < 6; m++) begin
      for (c = 0; c < 6; c++) begin
        n = int'(rand_bits(5) % 21);
        configure_map(map_list[m], 8'(rand_bits(8)), 24'(rand_bits(24)),
                      (24'd1 << n) - 24'd1);
        repeat (10) begin
          bus_access(random_addr(),
                     (rand_bits(1) != 0) ? 8'h3F : 8'(rand_bits(8)),
                     rand_bits(1) != 0);
        end
      end
    end

    $display("No errors");
    $finish;
  end

endmodule

// ==== src.f ====
+incdir+logic
+incdir+sim
logic/cart_map_pkg.sv
logic/cfg_bus_pkg.sv
logic/cart_config_regs.sv
logic/cart_addr_map.sv
logic/cart_mem_request.sv
logic/cart_top.sv
sim/tb_cart_top.sv
